/* verilog/arp_pkg.sv */
// ARP engine package with protocol constants, retry timing and shared enums
package arp_pkg;

    // Frame field constants checked on receive
    localparam logic [15:0] ETH_TYPE_ARP   = 16'h0806;
    localparam logic [15:0] ARP_HTYPE_ETH  = 16'h0001;
    localparam logic [15:0] ARP_PTYPE_IPV4 = 16'h0800;

    localparam logic [47:0] MAC_BROADCAST = 48'hffff_ffff_ffff;

    // Direct-mapped cache, indexed by the low IP bits
    localparam int CACHE_ADDR_WIDTH = 4;
    localparam int CACHE_DEPTH      = 1 << CACHE_ADDR_WIDTH;

    // Request timing in clock cycles, sized for simulation
    localparam int REQUEST_RETRY_COUNT    = 4;
    localparam int REQUEST_RETRY_INTERVAL = 200;
    localparam int REQUEST_TIMEOUT        = 400;

    // Timer must hold the larger of the two reload values
    localparam int TIMER_MAX = (REQUEST_TIMEOUT > REQUEST_RETRY_INTERVAL) ?
                               REQUEST_TIMEOUT : REQUEST_RETRY_INTERVAL;
    localparam int TIMER_WIDTH     = $clog2(TIMER_MAX + 1);
    localparam int RETRY_CNT_WIDTH = $clog2(REQUEST_RETRY_COUNT + 1);

    typedef enum logic [15:0] {
        ARP_REQUEST = 16'd1,
        ARP_REPLY   = 16'd2
    } arp_oper_e;

    // Lookup FSM states
    typedef enum logic [1:0] {
        RES_IDLE,
        RES_QUERY,
        RES_WAIT,
        RES_RESPOND
    } resolver_state_e;

endpackage

/* verilog/arp_cache.sv */
// Direct-mapped IP-to-MAC cache with a registered lookup and a one-cycle clear
`timescale 1ns/1ns

module arp_cache
    import arp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        clear_cache,
    input  logic        cache_wr_en,
    input  logic [31:0] cache_wr_ip,
    input  logic [47:0] cache_wr_mac,
    input  logic        cache_query_en,
    input  logic [31:0] cache_query_ip,
    output logic        cache_hit,
    output logic [47:0] cache_mac
);

    logic [CACHE_DEPTH-1:0] entry_valid;
    logic [31:0]            ip_mem  [CACHE_DEPTH];
    logic [47:0]            mac_mem [CACHE_DEPTH];

    logic [CACHE_ADDR_WIDTH-1:0] wr_idx;
    logic [CACHE_ADDR_WIDTH-1:0] query_idx;

    assign wr_idx    = cache_wr_ip[CACHE_ADDR_WIDTH-1:0];
    assign query_idx = cache_query_ip[CACHE_ADDR_WIDTH-1:0];

    // Valid bits; a clear wipes every entry, even one written in the same cycle
    always_ff @(posedge clk) begin
        if (rst || clear_cache) begin
            entry_valid <= '0;
        end else if (cache_wr_en) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (cache_wr_en) begin
            ip_mem[wr_idx]  <= cache_wr_ip;
            mac_mem[wr_idx] <= cache_wr_mac;
        end
    end

    // Registered read, the stored IP must match the whole query address
    always_ff @(posedge clk) begin
        if (rst) begin
            cache_hit <= 1'b0;
        end else begin
            cache_hit <= cache_query_en && entry_valid[query_idx] &&
                         (ip_mem[query_idx] == cache_query_ip);
        end
    end

    always_ff @(posedge clk) begin
        cache_mac <= mac_mem[query_idx];
    end

endmodule

/* verilog/arp_frame_handler.sv */
// Receive side of the ARP engine, checks frames, learns senders and raises replies
`timescale 1ns/1ns

module arp_frame_handler
    import arp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        rx_frame_valid,
    output logic        rx_frame_ready,
    input  logic [47:0] rx_eth_src_mac,
    input  logic [47:0] rx_arp_sha,
    input  logic [47:0] rx_arp_tha,
    input  logic [15:0] rx_eth_type,
    input  logic [15:0] rx_arp_htype,
    input  logic [15:0] rx_arp_ptype,
    input  arp_oper_e   rx_arp_oper,
    input  logic [31:0] rx_arp_spa,
    input  logic [31:0] rx_arp_tpa,
    input  logic [31:0] local_ip,
    input  logic        slot_free,
    output logic        cache_wr_en,
    output logic [31:0] cache_wr_ip,
    output logic [47:0] cache_wr_mac,
    output logic        reply_en,
    output logic [47:0] reply_dest_mac,
    output logic [31:0] reply_tpa
);

    logic rx_accept;
    logic type_ok;

    // Frames only enter when a reply would have somewhere to go
    assign rx_frame_ready = slot_free;
    assign rx_accept      = rx_frame_valid && rx_frame_ready;

    assign type_ok = (rx_eth_type == ETH_TYPE_ARP) &&
                     (rx_arp_htype == ARP_HTYPE_ETH) &&
                     (rx_arp_ptype == ARP_PTYPE_IPV4);

    // Reply goes straight to the slot register, so it leaves one cycle after accept
    assign reply_en       = rx_accept && type_ok && (rx_arp_oper == ARP_REQUEST) &&
                            (rx_arp_tpa == local_ip);
    assign reply_dest_mac = rx_eth_src_mac;
    assign reply_tpa      = rx_arp_spa;

    // Learn the sender pair of every valid ARP frame
    always_ff @(posedge clk) begin
        if (rst) begin
            cache_wr_en <= 1'b0;
        end else begin
            cache_wr_en <= rx_accept && type_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_accept) begin
            cache_wr_ip  <= rx_arp_spa;
            cache_wr_mac <= rx_arp_sha;
        end
    end

endmodule

/* verilog/arp_tx_select.sv */
// Single outgoing ARP frame slot, resolver requests take priority over replies
`timescale 1ns/1ns

module arp_tx_select
    import arp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        reply_en,
    input  logic [47:0] reply_dest_mac,
    input  logic [31:0] reply_tpa,
    input  logic        req_en,
    input  logic [31:0] req_tpa,
    output logic        slot_free,
    output logic        tx_frame_valid,
    input  logic        tx_frame_ready,
    output logic [47:0] tx_eth_dest_mac,
    output logic [47:0] tx_arp_tha,
    output arp_oper_e   tx_arp_oper,
    output logic [31:0] tx_arp_tpa
);

    // Empty now, or emptied by the transfer in this cycle
    assign slot_free = !tx_frame_valid || tx_frame_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_frame_valid <= 1'b0;
        end else if (req_en || reply_en) begin
            tx_frame_valid <= 1'b1;
        end else if (tx_frame_ready) begin
            tx_frame_valid <= 1'b0;
        end
    end

    // A request overwrites whatever the slot holds, a colliding reply is lost
    always_ff @(posedge clk) begin
        if (req_en) begin
            tx_eth_dest_mac <= MAC_BROADCAST;
            tx_arp_tha      <= '0;
            tx_arp_oper     <= ARP_REQUEST;
            tx_arp_tpa      <= req_tpa;
        end else if (reply_en) begin
            tx_eth_dest_mac <= reply_dest_mac;
            tx_arp_tha      <= reply_dest_mac;
            tx_arp_oper     <= ARP_REPLY;
            tx_arp_tpa      <= reply_tpa;
        end
    end

endmodule

/* verilog/arp_resolver.sv */
// Lookup FSM that routes by subnet, queries the cache and retries ARP requests on a miss
`timescale 1ns/1ns

module arp_resolver
    import arp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        lookup_valid,
    output logic        lookup_ready,
    input  logic [31:0] lookup_ip,
    output logic        response_valid,
    input  logic        response_ready,
    output logic        response_error,
    output logic [47:0] response_mac,
    input  logic [31:0] gateway_ip,
    input  logic [31:0] subnet_mask,
    output logic        cache_query_en,
    output logic [31:0] cache_query_ip,
    input  logic        cache_hit,
    input  logic [47:0] cache_mac,
    output logic        req_en,
    output logic [31:0] req_tpa
);

    resolver_state_e state;
    resolver_state_e state_next;

    logic [31:0]                target_ip;
    logic [31:0]                target_next;
    logic [TIMER_WIDTH-1:0]     timer;
    logic [TIMER_WIDTH-1:0]     timer_next;
    logic [RETRY_CNT_WIDTH-1:0] retry_cnt;
    logic [RETRY_CNT_WIDTH-1:0] retry_next;
    logic                       query_issued;
    logic                       issued_next;
    logic                       resp_load;
    logic                       resp_error_next;
    logic [47:0]                resp_mac_next;
    logic                       is_broadcast;
    logic                       in_subnet;

    // Host bits all set means subnet broadcast
    assign is_broadcast = ~(lookup_ip | subnet_mask) == 32'd0;
    assign in_subnet    = ((lookup_ip ^ gateway_ip) & subnet_mask) == 32'd0;

    assign response_valid = (state == RES_RESPOND);
    assign cache_query_en = (state == RES_QUERY) || (state == RES_WAIT);
    assign cache_query_ip = target_ip;
    assign req_tpa        = target_ip;

    always_comb begin
        state_next      = state;
        target_next     = target_ip;
        timer_next      = timer;
        retry_next      = retry_cnt;
        issued_next     = query_issued;
        resp_load       = 1'b0;
        resp_error_next = 1'b0;
        resp_mac_next   = '0;
        req_en          = 1'b0;

        case (state)
            RES_IDLE: begin
                if (lookup_valid && lookup_ready) begin
                    if (is_broadcast) begin
                        state_next    = RES_RESPOND;
                        resp_load     = 1'b1;
                        resp_mac_next = MAC_BROADCAST;
                    end else begin
                        state_next  = RES_QUERY;
                        issued_next = 1'b0;
                        target_next = in_subnet ? lookup_ip : gateway_ip;
                    end
                end
            end
            RES_QUERY: begin
                // First cycle issues the query, second one reads the result
                issued_next = 1'b1;
                if (query_issued) begin
                    if (cache_hit) begin
                        state_next    = RES_RESPOND;
                        resp_load     = 1'b1;
                        resp_mac_next = cache_mac;
                    end else begin
                        state_next = RES_WAIT;
                        req_en     = 1'b1;
                        retry_next = RETRY_CNT_WIDTH'(REQUEST_RETRY_COUNT - 1);
                        if (REQUEST_RETRY_COUNT > 1) begin
                            timer_next = TIMER_WIDTH'(REQUEST_RETRY_INTERVAL - 1);
                        end else begin
                            timer_next = TIMER_WIDTH'(REQUEST_TIMEOUT - 1);
                        end
                    end
                end
            end
            RES_WAIT: begin
                // A reply lands in the cache, so a hit ends the wait
                if (cache_hit) begin
                    state_next    = RES_RESPOND;
                    resp_load     = 1'b1;
                    resp_mac_next = cache_mac;
                end else if (timer == '0) begin
                    if (retry_cnt != '0) begin
                        req_en     = 1'b1;
                        retry_next = retry_cnt - 1'b1;
                        if (retry_cnt > 1) begin
                            timer_next = TIMER_WIDTH'(REQUEST_RETRY_INTERVAL - 1);
                        end else begin
                            timer_next = TIMER_WIDTH'(REQUEST_TIMEOUT - 1);
                        end
                    end else begin
                        // Out of retries
                        state_next      = RES_RESPOND;
                        resp_load       = 1'b1;
                        resp_error_next = 1'b1;
                    end
                end else begin
                    timer_next = timer - 1'b1;
                end
            end
            RES_RESPOND: begin
                if (response_ready) begin
                    state_next = RES_IDLE;
                end
            end
            default: begin
                state_next = RES_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= RES_IDLE;
            lookup_ready <= 1'b0;
            timer        <= '0;
            retry_cnt    <= '0;
            query_issued <= 1'b0;
        end else begin
            state        <= state_next;
            lookup_ready <= (state_next == RES_IDLE);
            timer        <= timer_next;
            retry_cnt    <= retry_next;
            query_issued <= issued_next;
        end
    end

    always_ff @(posedge clk) begin
        target_ip <= target_next;
        if (resp_load) begin
            response_error <= resp_error_next;
            response_mac   <= resp_mac_next;
        end
    end

endmodule

/* verilog/arp_top.sv */
// ARP engine top level joining frame handling, transmit slot, resolver and cache
`timescale 1ns/1ns

module arp_top
    import arp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Parsed receive frame
    input  logic        rx_frame_valid,
    output logic        rx_frame_ready,
    input  logic [47:0] rx_eth_src_mac,
    input  logic [15:0] rx_eth_type,
    input  logic [15:0] rx_arp_htype,
    input  logic [15:0] rx_arp_ptype,
    input  arp_oper_e   rx_arp_oper,
    input  logic [47:0] rx_arp_sha,
    input  logic [31:0] rx_arp_spa,
    input  logic [47:0] rx_arp_tha,
    input  logic [31:0] rx_arp_tpa,

    // Outgoing frame, constant fields are added downstream
    output logic        tx_frame_valid,
    input  logic        tx_frame_ready,
    output logic [47:0] tx_eth_dest_mac,
    output arp_oper_e   tx_arp_oper,
    output logic [47:0] tx_arp_tha,
    output logic [31:0] tx_arp_tpa,

    // Lookup
    input  logic        lookup_valid,
    output logic        lookup_ready,
    input  logic [31:0] lookup_ip,
    output logic        response_valid,
    input  logic        response_ready,
    output logic        response_error,
    output logic [47:0] response_mac,

    // Configuration
    input  logic [47:0] local_mac,
    input  logic [31:0] local_ip,
    input  logic [31:0] gateway_ip,
    input  logic [31:0] subnet_mask,
    input  logic        clear_cache
);

    logic        slot_free;
    logic        cache_wr_en;
    logic [31:0] cache_wr_ip;
    logic [47:0] cache_wr_mac;
    logic        cache_query_en;
    logic [31:0] cache_query_ip;
    logic        cache_hit;
    logic [47:0] cache_mac;
    logic        reply_en;
    logic [47:0] reply_dest_mac;
    logic [31:0] reply_tpa;
    logic        req_en;
    logic [31:0] req_tpa;

    arp_frame_handler frame_handler0 (
        .clk            (clk),
        .rst            (rst),
        .rx_frame_valid (rx_frame_valid),
        .rx_frame_ready (rx_frame_ready),
        .rx_eth_src_mac (rx_eth_src_mac),
        .rx_arp_sha     (rx_arp_sha),
        .rx_arp_tha     (rx_arp_tha),
        .rx_eth_type    (rx_eth_type),
        .rx_arp_htype   (rx_arp_htype),
        .rx_arp_ptype   (rx_arp_ptype),
        .rx_arp_oper    (rx_arp_oper),
        .rx_arp_spa     (rx_arp_spa),
        .rx_arp_tpa     (rx_arp_tpa),
        .local_ip       (local_ip),
        .slot_free      (slot_free),
        .cache_wr_en    (cache_wr_en),
        .cache_wr_ip    (cache_wr_ip),
        .cache_wr_mac   (cache_wr_mac),
        .reply_en       (reply_en),
        .reply_dest_mac (reply_dest_mac),
        .reply_tpa      (reply_tpa)
    );

    arp_tx_select tx_select0 (
        .clk             (clk),
        .rst             (rst),
        .reply_en        (reply_en),
        .reply_dest_mac  (reply_dest_mac),
        .reply_tpa       (reply_tpa),
        .req_en          (req_en),
        .req_tpa         (req_tpa),
        .slot_free       (slot_free),
        .tx_frame_valid  (tx_frame_valid),
        .tx_frame_ready  (tx_frame_ready),
        .tx_eth_dest_mac (tx_eth_dest_mac),
        .tx_arp_tha      (tx_arp_tha),
        .tx_arp_oper     (tx_arp_oper),
        .tx_arp_tpa      (tx_arp_tpa)
    );

    arp_resolver resolver0 (
        .clk            (clk),
        .rst            (rst),
        .lookup_valid   (lookup_valid),
        .lookup_ready   (lookup_ready),
        .lookup_ip      (lookup_ip),
        .response_valid (response_valid),
        .response_ready (response_ready),
        .response_error (response_error),
        .response_mac   (response_mac),
        .gateway_ip     (gateway_ip),
        .subnet_mask    (subnet_mask),
        .cache_query_en (cache_query_en),
        .cache_query_ip (cache_query_ip),
        .cache_hit      (cache_hit),
        .cache_mac      (cache_mac),
        .req_en         (req_en),
        .req_tpa        (req_tpa)
    );

    arp_cache cache0 (
        .clk            (clk),
        .rst            (rst),
        .clear_cache    (clear_cache),
        .cache_wr_en    (cache_wr_en),
        .cache_wr_ip    (cache_wr_ip),
        .cache_wr_mac   (cache_wr_mac),
        .cache_query_en (cache_query_en),
        .cache_query_ip (cache_query_ip),
        .cache_hit      (cache_hit),
        .cache_mac      (cache_mac)
    );

endmodule

/* verif/arp_tb_asserts.sv */
// Handshake and reset checks on the ARP engine ports, bound into the top level
`timescale 1ns/1ns

module arp_tb_asserts (
    input logic        clk,
    input logic        rst,
    input logic        tx_frame_valid,
    input logic        tx_frame_ready,
    input logic        lookup_ready,
    input logic        response_valid,
    input logic        response_ready,
    input logic        response_error,
    input logic [47:0] response_mac
);

    // Response holds until taken
    resp_hold: assert property (@(posedge clk) disable iff (rst)
        response_valid && !response_ready |=>
            response_valid && $stable(response_mac) && $stable(response_error))
        else $error("response changed before response_ready");

    // A request may replace the held frame, so only valid must persist
    tx_hold: assert property (@(posedge clk) disable iff (rst)
        tx_frame_valid && !tx_frame_ready |=> tx_frame_valid)
        else $error("tx_frame_valid dropped before tx_frame_ready");

    ready_excl: assert property (@(posedge clk) disable iff (rst)
        !(lookup_ready && response_valid))
        else $error("lookup_ready and response_valid high together");

    reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> !tx_frame_valid && !lookup_ready && !response_valid)
        else $error("outputs active in the first cycle after reset");

endmodule

bind arp_top arp_tb_asserts asserts0 (
    .clk            (clk),
    .rst            (rst),
    .tx_frame_valid (tx_frame_valid),
    .tx_frame_ready (tx_frame_ready),
    .lookup_ready   (lookup_ready),
    .response_valid (response_valid),
    .response_ready (response_ready),
    .response_error (response_error),
    .response_mac   (response_mac)
);

/* verif/arp_tb.sv */
// Table-driven testbench that runs ARP engine stimulus through the top level
`timescale 1ns/1ns

module arp_tb
    import arp_pkg::*;
();

    typedef enum logic [1:0] {
        STEP_RX,
        STEP_LOOKUP,
        STEP_CLEAR,
        STEP_IDLE
    } step_kind_e;

    // One table row
    // mac and ip hold the sender pair for rx steps and the expected MAC and target for lookups
    typedef struct packed {
        step_kind_e  kind;
        logic [15:0] eth_type;
        arp_oper_e   oper;
        logic [47:0] mac;
        logic [31:0] ip;
        logic [31:0] tpa;
        logic [31:0] feed_ip;
        logic [47:0] feed_mac;
        logic [2:0]  exp_tx;
        logic        exp_err;
        logic [3:0]  exp_latency;
        logic        backpressure;
        logic [5:0]  gap;
    } step_t;

    typedef struct packed {
        logic [47:0] dest;
        arp_oper_e   oper;
        logic [47:0] tha;
        logic [31:0] tpa;
    } tx_frame_t;

    logic        clk;
    logic        rst;
    logic        rx_frame_valid;
    logic        rx_frame_ready;
    logic [47:0] rx_eth_src_mac;
    logic [15:0] rx_eth_type;
    logic [15:0] rx_arp_htype;
    logic [15:0] rx_arp_ptype;
    arp_oper_e   rx_arp_oper;
    logic [47:0] rx_arp_sha;
    logic [31:0] rx_arp_spa;
    logic [47:0] rx_arp_tha;
    logic [31:0] rx_arp_tpa;
    logic        tx_frame_valid;
    logic        tx_frame_ready;
    logic [47:0] tx_eth_dest_mac;
    arp_oper_e   tx_arp_oper;
    logic [47:0] tx_arp_tha;
    logic [31:0] tx_arp_tpa;
    logic        lookup_valid;
    logic        lookup_ready;
    logic [31:0] lookup_ip;
    logic        response_valid;
    logic        response_ready;
    logic        response_error;
    logic [47:0] response_mac;
    logic [47:0] local_mac;
    logic [31:0] local_ip;
    logic [31:0] gateway_ip;
    logic [31:0] subnet_mask;
    logic        clear_cache;

    int          errors = 0;
    int          checks = 0;
    int          seed = 32'h6b8b_2347;
    int          timeout_limit = 0;
    int          cycle_cnt = 0;
    int          rx_accepts = 0;
    int          lookup_accepts = 0;
    int          lookup_acc_cycle = 0;
    int          resp_rise_cycle = 0;
    int          resp_count = 0;
    logic        resp_valid_prev = 1'b0;
    logic [47:0] resp_mac_seen;
    logic        resp_err_seen;
    bit          bp_active = 1'b0;
    logic [47:0] rand_mac [8];
    step_t       steps [$];
    tx_frame_t   tx_q [$];

    arp_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Monitor of frames, handshakes and responses at the rising edge
    always @(posedge clk) begin
        cycle_cnt       <= cycle_cnt + 1;
        resp_valid_prev <= response_valid;
        if (!rst) begin
            if (tx_frame_valid && tx_frame_ready) begin
                tx_q.push_back({tx_eth_dest_mac, tx_arp_oper, tx_arp_tha, tx_arp_tpa});
            end
            if (rx_frame_valid && rx_frame_ready) begin
                rx_accepts <= rx_accepts + 1;
            end
            if (lookup_valid && lookup_ready) begin
                lookup_accepts   <= lookup_accepts + 1;
                lookup_acc_cycle <= cycle_cnt;
            end
            if (response_valid && !resp_valid_prev) begin
                resp_rise_cycle <= cycle_cnt;
            end
            if (response_valid && response_ready) begin
                resp_count    <= resp_count + 1;
                resp_mac_seen <= response_mac;
                resp_err_seen <= response_error;
            end
        end
    end

    initial begin
        @(negedge clk);
        while (cycle_cnt < timeout_limit) begin
            @(negedge clk);
        end
        $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        if (bp_active) begin
            tx_frame_ready = 1'($random(seed));
        end
    endtask

    task automatic send_frame(input logic [15:0] eth_type, input arp_oper_e oper,
                              input logic [47:0] mac, input logic [31:0] spa,
                              input logic [31:0] tpa);
        int start;
        start          = rx_accepts;
        rx_frame_valid = 1'b1;
        rx_eth_src_mac = mac;
        rx_eth_type    = eth_type;
        rx_arp_oper    = oper;
        rx_arp_sha     = mac;
        rx_arp_spa     = spa;
        rx_arp_tpa     = tpa;
        while (rx_accepts == start) begin
            next_cycle();
        end
        rx_frame_valid = 1'b0;
    endtask

    task automatic wait_tx_frames(input int count);
        while (tx_q.size() < count) begin
            next_cycle();
        end
    endtask

    function automatic tx_frame_t make_frame(input logic [47:0] dest, input arp_oper_e oper,
                                             input logic [47:0] tha, input logic [31:0] tpa);
        tx_frame_t f;
        f.dest = dest;
        f.oper = oper;
        f.tha  = tha;
        f.tpa  = tpa;
        return f;
    endfunction

    task automatic check_tx_frame(input tx_frame_t exp);
        tx_frame_t got;
        if (tx_q.size() == 0) begin
            errors++;
            $display("Expected tx frame for tpa 0x%0h never appeared", exp.tpa);
        end else begin
            got = tx_q.pop_front();
            check_value("tx_eth_dest_mac", 64'(got.dest), 64'(exp.dest));
            check_value("tx_arp_oper", 64'(got.oper), 64'(exp.oper));
            check_value("tx_arp_tha", 64'(got.tha), 64'(exp.tha));
            check_value("tx_arp_tpa", 64'(got.tpa), 64'(exp.tpa));
        end
    endtask

    task automatic flush_tx_frames();
        tx_frame_t extra;
        while (tx_q.size() != 0) begin
            extra = tx_q.pop_front();
            errors++;
            $display("Unexpected tx frame with oper %0d for tpa 0x%0h seen by %0t ns",
                     extra.oper, extra.tpa, $time);
        end
    endtask

    function automatic void add_rx(input logic [15:0] eth_type, input arp_oper_e oper,
                                   input logic [47:0] mac, input logic [31:0] spa,
                                   input logic [31:0] tpa, input int exp_tx, input bit bp);
        step_t s;
        s              = '0;
        s.kind         = STEP_RX;
        s.eth_type     = eth_type;
        s.oper         = oper;
        s.mac          = mac;
        s.ip           = spa;
        s.tpa          = tpa;
        s.exp_tx       = 3'(exp_tx);
        s.backpressure = bp;
        steps.push_back(s);
    endfunction

    function automatic void add_lookup(input logic [31:0] ip, input logic [47:0] mac,
                                       input bit err, input int exp_tx, input int latency,
                                       input logic [31:0] feed_ip, input logic [47:0] feed_mac);
        step_t s;
        s             = '0;
        s.kind        = STEP_LOOKUP;
        s.oper        = ARP_REQUEST;
        s.ip          = ip;
        s.mac         = mac;
        s.exp_err     = err;
        s.exp_tx      = 3'(exp_tx);
        s.exp_latency = 4'(latency);
        s.feed_ip     = feed_ip;
        s.feed_mac    = feed_mac;
        steps.push_back(s);
    endfunction

    function automatic void add_other(input step_kind_e kind, input int gap);
        step_t s;
        s      = '0;
        s.kind = kind;
        s.oper = ARP_REQUEST;
        s.gap  = 6'(gap);
        steps.push_back(s);
    endfunction

    // Misses may run through every retry and the final timeout
    function automatic int step_budget(input step_t s);
        if (s.kind == STEP_LOOKUP && s.exp_tx != 0) begin
            return REQUEST_TIMEOUT + REQUEST_RETRY_COUNT * REQUEST_RETRY_INTERVAL + 50;
        end
        return 50;
    endfunction

    task automatic run_step(input step_t s);
        int start_acc;
        int start_resp;
        case (s.kind)
            STEP_RX: begin
                bp_active = s.backpressure;
                send_frame(s.eth_type, s.oper, s.mac, s.ip, s.tpa);
                wait_tx_frames(int'(s.exp_tx));
                bp_active      = 1'b0;
                tx_frame_ready = 1'b1;
                repeat (4) next_cycle();
                if (s.exp_tx != 0) begin
                    check_tx_frame(make_frame(s.mac, ARP_REPLY, s.mac, s.ip));
                end
            end
            STEP_LOOKUP: begin
                start_acc    = lookup_accepts;
                start_resp   = resp_count;
                lookup_valid = 1'b1;
                lookup_ip    = s.ip;
                while (lookup_accepts == start_acc) begin
                    next_cycle();
                end
                lookup_valid = 1'b0;
                // Target answers after the first broadcast request
                if (s.feed_ip != 32'd0) begin
                    wait_tx_frames(1);
                    send_frame(ETH_TYPE_ARP, ARP_REPLY, s.feed_mac, s.feed_ip, local_ip);
                end
                while (!response_valid) begin
                    next_cycle();
                end
                response_ready = 1'b1;
                while (resp_count == start_resp) begin
                    next_cycle();
                end
                response_ready = 1'b0;
                check_value("response_mac", 64'(resp_mac_seen), 64'(s.mac));
                check_value("response_error", 64'(resp_err_seen), 64'(s.exp_err));
                if (s.exp_latency != 0) begin
                    check_value("response_valid latency",
                                64'(resp_rise_cycle - lookup_acc_cycle), 64'(s.exp_latency));
                end
                repeat (4) next_cycle();
                for (int i = 0; i < int'(s.exp_tx); i++) begin
                    check_tx_frame(make_frame(MAC_BROADCAST, ARP_REQUEST, 48'd0, s.ip));
                end
            end
            STEP_CLEAR: begin
                clear_cache = 1'b1;
                next_cycle();
                clear_cache = 1'b0;
                repeat (2) next_cycle();
            end
            default: begin
                repeat (int'(s.gap)) next_cycle();
            end
        endcase
        flush_tx_frames();
    endtask

    initial begin
        rst            = 1'b1;
        rx_frame_valid = 1'b0;
        rx_eth_src_mac = '0;
        rx_eth_type    = ETH_TYPE_ARP;
        rx_arp_htype   = ARP_HTYPE_ETH;
        rx_arp_ptype   = ARP_PTYPE_IPV4;
        rx_arp_oper    = ARP_REQUEST;
        rx_arp_sha     = '0;
        rx_arp_spa     = '0;
        rx_arp_tha     = '0;
        rx_arp_tpa     = '0;
        tx_frame_ready = 1'b1;
        lookup_valid   = 1'b0;
        lookup_ip      = '0;
        response_ready = 1'b0;
        local_mac      = 48'h02_00_00_00_00_05;
        local_ip       = 32'h0a00_0005;
        gateway_ip     = 32'h0a00_0001;
        subnet_mask    = 32'hffff_ff00;
        clear_cache    = 1'b0;

        for (int i = 0; i < 8; i++) begin
            rand_mac[i][47:32] = 16'($random(seed));
            rand_mac[i][31:0]  = $random(seed);
        end

        // Replies with one of them under random back-pressure
        add_rx(ETH_TYPE_ARP, ARP_REQUEST, rand_mac[0], 32'h0a00_0014, local_ip, 1, 1'b0);
        add_rx(ETH_TYPE_ARP, ARP_REQUEST, rand_mac[1], 32'h0a00_0015, local_ip, 1, 1'b1);
        add_rx(ETH_TYPE_ARP, ARP_REQUEST, rand_mac[2], 32'h0a00_0016, 32'h0a00_0063, 0, 1'b0);
        add_other(STEP_IDLE, 8);
        // Learn 10.0.0.7 and make sure a bad frame does not overwrite it
        add_rx(ETH_TYPE_ARP, ARP_REPLY, rand_mac[3], 32'h0a00_0007, local_ip, 0, 1'b0);
        add_rx(16'h0800, ARP_REQUEST, rand_mac[4], 32'h0a00_0007, local_ip, 0, 1'b0);
        add_lookup(32'h0a00_0007, rand_mac[3], 1'b0, 0, 3, 32'd0, 48'd0);
        // Off-subnet goes through the gateway
        add_rx(ETH_TYPE_ARP, ARP_REPLY, rand_mac[5], 32'h0a00_0001, local_ip, 0, 1'b0);
        add_lookup(32'h0808_0808, rand_mac[5], 1'b0, 0, 3, 32'd0, 48'd0);
        add_lookup(32'h0a00_00ff, MAC_BROADCAST, 1'b0, 0, 1, 32'd0, 48'd0);
        // Misses
        add_lookup(32'h0a00_0032, 48'd0, 1'b1, REQUEST_RETRY_COUNT, 0, 32'd0, 48'd0);
        add_lookup(32'h0a00_0009, rand_mac[6], 1'b0, 1, 0, 32'h0a00_0009, rand_mac[6]);
        add_other(STEP_CLEAR, 0);
        add_lookup(32'h0a00_0007, 48'd0, 1'b1, REQUEST_RETRY_COUNT, 0, 32'd0, 48'd0);

        timeout_limit = 20;
        foreach (steps[i]) begin
            timeout_limit += step_budget(steps[i]);
        end

        // Reset covers three rising edges, then drops on a falling edge
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        next_cycle();

        foreach (steps[i]) begin
            run_step(steps[i]);
        end

        repeat (10) next_cycle();
        flush_tx_frames();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* compile.f */
verilog/arp_pkg.sv
verilog/arp_cache.sv
verilog/arp_frame_handler.sv
verilog/arp_tx_select.sv
verilog/arp_resolver.sv
verilog/arp_top.sv
verif/arp_tb_asserts.sv
verif/arp_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module arp_tb -f compile.f -o arp_sim

result=$(./obj_dir/arp_sim) || true
echo "$result"

if echo "$result" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
